// ==== verilog/id_pkg.sv ====
// Shared widths, opcodes, encodings and bundles for the RV32I decode stage
package id_pkg;

  //////////////////////////////////////////////////
  // Widths and constants
  //////////////////////////////////////////////////
  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 32;

  // Link increment, uncompressed only
  localparam logic [XLEN-1:0] PC_INCR = 32'd4;

  // Major opcodes, instr[6:0]
  localparam logic [6:0] OPCODE_OP     = 7'b0110011;
  localparam logic [6:0] OPCODE_OPIMM  = 7'b0010011;
  localparam logic [6:0] OPCODE_LUI    = 7'b0110111;
  localparam logic [6:0] OPCODE_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPCODE_JAL    = 7'b1101111;
  localparam logic [6:0] OPCODE_JALR   = 7'b1100111;
  localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;
  localparam logic [6:0] OPCODE_LOAD   = 7'b0000011;
  localparam logic [6:0] OPCODE_STORE  = 7'b0100011;

  // Load/store access size on data_type
  localparam logic [1:0] DATA_TYPE_WORD = 2'b00;
  localparam logic [1:0] DATA_TYPE_HALF = 2'b01;
  localparam logic [1:0] DATA_TYPE_BYTE = 2'b10;

  //////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////
  // BLT and BLTU share SLT and SLTU
  typedef enum logic [3:0] {
    ALU_NOP, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL,
    ALU_SRA, ALU_SLT, ALU_SLTU, ALU_EQ, ALU_NE, ALU_GE, ALU_GEU
  } alu_op_e;

  typedef enum logic [1:0] {OP_A_REG, OP_A_PC, OP_A_ZERO} op_a_sel_e;
  typedef enum logic [1:0] {OP_B_REG, OP_B_IMM, OP_B_PCINCR} op_b_sel_e;
  typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_sel_e;
  typedef enum logic [1:0] {JUMP_NONE, JUMP_JAL, JUMP_JALR, JUMP_BRANCH} jump_e;
  typedef enum logic [1:0] {FWD_REGFILE, FWD_ALU, FWD_WB} fwd_sel_e;

  //////////////////////////////////////////////////
  // Instruction word and pipeline bundles
  //////////////////////////////////////////////////
  // Register view and store view of one word
  typedef union packed {
    struct packed {
      logic [6:0]            funct7;
      logic [REG_ADDR_W-1:0] rs2;
      logic [REG_ADDR_W-1:0] rs1;
      logic [2:0]            funct3;
      logic [REG_ADDR_W-1:0] rd;
      logic [6:0]            opcode;
    } r;
    struct packed {
      logic [6:0]            imm_hi;
      logic [REG_ADDR_W-1:0] rs2;
      logic [REG_ADDR_W-1:0] rs1;
      logic [2:0]            funct3;
      logic [4:0]            imm_lo;
      logic [6:0]            opcode;
    } s;
  } instr_u;

  // One register file write port
  typedef struct packed {
    logic                  we;
    logic [REG_ADDR_W-1:0] waddr;
    logic [XLEN-1:0]       wdata;
  } rf_write_t;

  // Decoded control, all zero is a bubble
  typedef struct packed {
    alu_op_e   alu_op;
    op_a_sel_e op_a_sel;
    op_b_sel_e op_b_sel;
    jump_e     jump;
    logic      alu_we;
    logic      mem_we;
    logic      data_req;
    logic      data_we;
    logic [1:0] data_type;
    logic      data_sign_ext;
    logic      illegal;
  } id_ctrl_t;

  // Registered ID/EX contents
  typedef struct packed {
    alu_op_e               alu_op;
    logic [XLEN-1:0]       operand_a;
    logic [XLEN-1:0]       operand_b;
    logic [XLEN-1:0]       operand_c;
    logic [XLEN-1:0]       rb_data;
    logic [REG_ADDR_W-1:0] alu_waddr;
    logic                  alu_we;
    logic [REG_ADDR_W-1:0] waddr;
    logic                  we;
    logic                  data_req;
    logic                  data_we;
    logic [1:0]            data_type;
    logic                  data_sign_ext;
    jump_e                 jump;
  } id_ex_t;

endpackage

// ==== verilog/instr_decoder.sv ====
// Combinational RV32I decoder, turns one instruction word into control and immediate
`timescale 1ns/1ps

module instr_decoder
  import id_pkg::*;
(
  input  instr_u                instr_i,
  output id_ctrl_t              ctrl_o,
  output logic [XLEN-1:0]       imm_o,
  output logic [REG_ADDR_W-1:0] rs1_o,
  output logic [REG_ADDR_W-1:0] rs2_o,
  output logic [REG_ADDR_W-1:0] rd_o
);

  imm_sel_e   imm_sel;
  logic       illegal;
  logic [2:0] funct3;
  logic [6:0] funct7;

  // ALU op shared by OP and OP-IMM, alt picks SUB or SRA
  function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  // Register fields sit at the same place in every format
  assign rs1_o  = instr_i.r.rs1;
  assign rs2_o  = instr_i.r.rs2;
  assign rd_o   = instr_i.r.rd;
  assign funct3 = instr_i.r.funct3;
  assign funct7 = instr_i.r.funct7;

  //////////////////////////////////////////////////
  // Control decode
  //////////////////////////////////////////////////
  always_comb
  begin
    ctrl_o  = '0;
    imm_sel = IMM_I;
    illegal = 1'b0;
    case (instr_i.r.opcode)
      OPCODE_OP:
      begin
        ctrl_o.alu_we = 1'b1;
        ctrl_o.alu_op = arith_op(funct3, funct7[5]);
        // Only SUB and SRA take the alternate funct7
        if (funct7 == 7'b0100000)
          illegal = (funct3 != 3'b000) && (funct3 != 3'b101);
        else
          illegal = (funct7 != 7'b0000000);
      end
      OPCODE_OPIMM:
      begin
        ctrl_o.alu_we   = 1'b1;
        ctrl_o.op_b_sel = OP_B_IMM;
        // No SUBI, funct7[5] only matters for shifts
        ctrl_o.alu_op   = arith_op(funct3, funct7[5] && (funct3 == 3'b101));
        if (funct3 == 3'b001)
          illegal = (funct7 != 7'b0000000);
        else if (funct3 == 3'b101)
          illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
      end
      OPCODE_LUI:
      begin
        ctrl_o.alu_we   = 1'b1;
        ctrl_o.alu_op   = ALU_ADD;
        ctrl_o.op_a_sel = OP_A_ZERO;
        ctrl_o.op_b_sel = OP_B_IMM;
        imm_sel         = IMM_U;
      end
      OPCODE_AUIPC:
      begin
        ctrl_o.alu_we   = 1'b1;
        ctrl_o.alu_op   = ALU_ADD;
        ctrl_o.op_a_sel = OP_A_PC;
        ctrl_o.op_b_sel = OP_B_IMM;
        imm_sel         = IMM_U;
      end
      OPCODE_JAL, OPCODE_JALR:
      begin
        // Link value PC + 4, target goes on operand C
        ctrl_o.alu_we   = 1'b1;
        ctrl_o.alu_op   = ALU_ADD;
        ctrl_o.op_a_sel = OP_A_PC;
        ctrl_o.op_b_sel = OP_B_PCINCR;
        if (instr_i.r.opcode == OPCODE_JAL)
        begin
          ctrl_o.jump = JUMP_JAL;
          imm_sel     = IMM_J;
        end
        else
        begin
          ctrl_o.jump = JUMP_JALR;
          illegal     = (funct3 != 3'b000);
        end
      end
      OPCODE_BRANCH:
      begin
        ctrl_o.jump = JUMP_BRANCH;
        imm_sel     = IMM_B;
        case (funct3)
          3'b000:  ctrl_o.alu_op = ALU_EQ;
          3'b001:  ctrl_o.alu_op = ALU_NE;
          3'b100:  ctrl_o.alu_op = ALU_SLT;
          3'b101:  ctrl_o.alu_op = ALU_GE;
          3'b110:  ctrl_o.alu_op = ALU_SLTU;
          3'b111:  ctrl_o.alu_op = ALU_GEU;
          default: illegal = 1'b1;
        endcase
      end
      OPCODE_LOAD:
      begin
        ctrl_o.alu_op        = ALU_ADD;
        ctrl_o.op_b_sel      = OP_B_IMM;
        ctrl_o.data_req      = 1'b1;
        ctrl_o.mem_we        = 1'b1;
        // funct3[2] marks the unsigned forms
        ctrl_o.data_sign_ext = ~funct3[2];
        case (funct3)
          3'b000, 3'b100: ctrl_o.data_type = DATA_TYPE_BYTE;
          3'b001, 3'b101: ctrl_o.data_type = DATA_TYPE_HALF;
          3'b010:         ctrl_o.data_type = DATA_TYPE_WORD;
          default:        illegal = 1'b1;
        endcase
      end
      OPCODE_STORE:
      begin
        ctrl_o.alu_op   = ALU_ADD;
        ctrl_o.op_b_sel = OP_B_IMM;
        ctrl_o.data_req = 1'b1;
        ctrl_o.data_we  = 1'b1;
        imm_sel         = IMM_S;
        case (funct3)
          3'b000:  ctrl_o.data_type = DATA_TYPE_BYTE;
          3'b001:  ctrl_o.data_type = DATA_TYPE_HALF;
          3'b010:  ctrl_o.data_type = DATA_TYPE_WORD;
          default: illegal = 1'b1;
        endcase
      end
      default: illegal = 1'b1;
    endcase

    // Illegal words leave as a bubble with only the flag set
    if (illegal)
      ctrl_o = '0;
    ctrl_o.illegal = illegal;
  end

  //////////////////////////////////////////////////
  // Immediate extraction, sign from instr[31]
  //////////////////////////////////////////////////
  always_comb
  begin
    case (imm_sel)
      IMM_S: imm_o = {{20{instr_i.s.imm_hi[6]}}, instr_i.s.imm_hi, instr_i.s.imm_lo};
      IMM_B: imm_o = {{20{instr_i.s.imm_hi[6]}}, instr_i.s.imm_lo[0],
                      instr_i.s.imm_hi[5:0], instr_i.s.imm_lo[4:1], 1'b0};
      IMM_U: imm_o = {funct7, instr_i.r.rs2, instr_i.r.rs1, funct3, 12'b0};
      // J format scrambles bits 30:12 across the register fields
      IMM_J: imm_o = {{12{funct7[6]}}, instr_i.r.rs1, funct3, instr_i.r.rs2[0],
                      funct7[5:0], instr_i.r.rs2[4:1], 1'b0};
      default: imm_o = {{20{funct7[6]}}, funct7, instr_i.r.rs2};
    endcase
  end

endmodule

// ==== verilog/register_file.sv ====
// 32 x 32 register file, two combinational reads, two clocked writes, x0 tied to zero
`timescale 1ns/1ps

module register_file
  import id_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  // Read ports
  input  logic [REG_ADDR_W-1:0] raddr_a_i,
  input  logic [REG_ADDR_W-1:0] raddr_b_i,
  output logic [XLEN-1:0]       rdata_a_o,
  output logic [XLEN-1:0]       rdata_b_o,
  // Write ports
  input  rf_write_t             alu_wr_i,
  input  rf_write_t             wb_wr_i
);

  // x0 has no storage
  logic [XLEN-1:0] regs_q [NUM_REGS-1:1];

  // Per-register write select, ALU port wins on collision
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 1; i < NUM_REGS; i++)
        regs_q[i] <= '0;
    end
    else
    begin
      for (int i = 1; i < NUM_REGS; i++)
      begin
        if (alu_wr_i.we && (alu_wr_i.waddr == REG_ADDR_W'(i)))
          regs_q[i] <= alu_wr_i.wdata;
        else if (wb_wr_i.we && (wb_wr_i.waddr == REG_ADDR_W'(i)))
          regs_q[i] <= wb_wr_i.wdata;
      end
    end
  end

  // Reads see the old content, same-cycle writes come via forwarding
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

// ==== verilog/operand_forward.sv ====
// Bypass of pending ALU and WB writes onto the rs1 and rs2 read data
`timescale 1ns/1ps

module operand_forward
  import id_pkg::*;
(
  input  logic [REG_ADDR_W-1:0] rs1_i,
  input  logic [REG_ADDR_W-1:0] rs2_i,
  input  logic [XLEN-1:0]       rf_a_i,
  input  logic [XLEN-1:0]       rf_b_i,
  input  rf_write_t             alu_wr_i,
  input  rf_write_t             wb_wr_i,
  output logic [XLEN-1:0]       fwd_a_o,
  output logic [XLEN-1:0]       fwd_b_o
);

  fwd_sel_e sel_a;
  fwd_sel_e sel_b;

  // Source pick, ALU result is younger so it goes first
  function automatic fwd_sel_e fwd_select(input logic [REG_ADDR_W-1:0] addr,
                                          input rf_write_t alu, input rf_write_t wb);
    if (addr == '0)
      return FWD_REGFILE;
    if (alu.we && (alu.waddr == addr))
      return FWD_ALU;
    if (wb.we && (wb.waddr == addr))
      return FWD_WB;
    return FWD_REGFILE;
  endfunction

  function automatic logic [XLEN-1:0] fwd_mux(input fwd_sel_e sel,
                                              input logic [XLEN-1:0] rf_data,
                                              input rf_write_t alu, input rf_write_t wb);
    case (sel)
      FWD_ALU: return alu.wdata;
      FWD_WB:  return wb.wdata;
      default: return rf_data;
    endcase
  endfunction

  assign sel_a = fwd_select(rs1_i, alu_wr_i, wb_wr_i);
  assign sel_b = fwd_select(rs2_i, alu_wr_i, wb_wr_i);

  // rs2 result doubles as store data
  assign fwd_a_o = fwd_mux(sel_a, rf_a_i, alu_wr_i, wb_wr_i);
  assign fwd_b_o = fwd_mux(sel_b, rf_b_i, alu_wr_i, wb_wr_i);

endmodule

// ==== verilog/operand_select.sv ====
// ALU operand muxes A, B and C, with the jump or branch target on operand C
`timescale 1ns/1ps

module operand_select
  import id_pkg::*;
(
  input  id_ctrl_t        ctrl_i,
  input  logic [XLEN-1:0] imm_i,
  input  logic [XLEN-1:0] pc_i,
  input  logic [XLEN-1:0] fwd_a_i,
  input  logic [XLEN-1:0] fwd_b_i,
  output logic [XLEN-1:0] op_a_o,
  output logic [XLEN-1:0] op_b_o,
  output logic [XLEN-1:0] op_c_o
);

  // Operand A
  always_comb
  begin
    case (ctrl_i.op_a_sel)
      OP_A_PC:   op_a_o = pc_i;
      OP_A_ZERO: op_a_o = '0;
      default:   op_a_o = fwd_a_i;
    endcase
  end

  // Operand B
  always_comb
  begin
    case (ctrl_i.op_b_sel)
      OP_B_IMM:    op_b_o = imm_i;
      OP_B_PCINCR: op_b_o = PC_INCR;
      default:     op_b_o = fwd_b_i;
    endcase
  end

  // Operand C, target adders
  always_comb
  begin
    case (ctrl_i.jump)
      // PC relative for JAL and branches
      JUMP_JAL, JUMP_BRANCH: op_c_o = pc_i + imm_i;
      // Register relative, low bit cleared in EX
      JUMP_JALR:             op_c_o = fwd_a_i + imm_i;
      default:               op_c_o = fwd_b_i;
    endcase
  end

endmodule

// ==== verilog/id_ex_regs.sv ====
// ID/EX pipeline register, bubble on reset and on illegal words, frozen while EX stalls
`timescale 1ns/1ps

module id_ex_regs
  import id_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  stall_i,
  input  id_ctrl_t              ctrl_i,
  input  logic [XLEN-1:0]       op_a_i,
  input  logic [XLEN-1:0]       op_b_i,
  input  logic [XLEN-1:0]       op_c_i,
  input  logic [XLEN-1:0]       rb_data_i,
  input  logic [REG_ADDR_W-1:0] rd_i,
  output id_ex_t                ex_o
);

  // All zero is ALU_NOP, JUMP_NONE and every enable low
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      ex_o <= '0;
    end
    else if (!stall_i)
    begin
      if (ctrl_i.illegal)
      begin
        ex_o <= '0;
      end
      else
      begin
        ex_o.alu_op        <= ctrl_i.alu_op;
        ex_o.operand_a     <= op_a_i;
        ex_o.operand_b     <= op_b_i;
        ex_o.operand_c     <= op_c_i;
        ex_o.rb_data       <= rb_data_i;
        // Both write paths target rd
        ex_o.alu_waddr     <= rd_i;
        ex_o.alu_we        <= ctrl_i.alu_we;
        ex_o.waddr         <= rd_i;
        ex_o.we            <= ctrl_i.mem_we;
        ex_o.data_req      <= ctrl_i.data_req;
        ex_o.data_we       <= ctrl_i.data_we;
        ex_o.data_type     <= ctrl_i.data_type;
        ex_o.data_sign_ext <= ctrl_i.data_sign_ext;
        ex_o.jump          <= ctrl_i.jump;
      end
    end
  end

endmodule

// ==== verilog/id_stage.sv ====
// Decode stage top level, decode, register read, forwarding and operand setup into ID/EX
`timescale 1ns/1ps

module id_stage
  import id_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,
  // Instruction from IF
  input  logic [XLEN-1:0] instr_rdata_i,
  input  logic [XLEN-1:0] pc_id_i,
  // EX back-pressure level
  input  logic            stall_ex_i,
  // Pending register writes
  input  rf_write_t       alu_wr_i,
  input  rf_write_t       wb_wr_i,
  // To EX
  output id_ex_t          ex_o,
  output logic            illegal_insn_o
);

  id_ctrl_t              ctrl;
  logic [XLEN-1:0]       imm;
  logic [REG_ADDR_W-1:0] rs1;
  logic [REG_ADDR_W-1:0] rs2;
  logic [REG_ADDR_W-1:0] rd;
  logic [XLEN-1:0]       rf_a;
  logic [XLEN-1:0]       rf_b;
  logic [XLEN-1:0]       fwd_a;
  logic [XLEN-1:0]       fwd_b;
  logic [XLEN-1:0]       op_a;
  logic [XLEN-1:0]       op_b;
  logic [XLEN-1:0]       op_c;

  //////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////
  instr_decoder decoder_i (
    .instr_i (instr_u'(instr_rdata_i)),
    .ctrl_o  (ctrl),
    .imm_o   (imm),
    .rs1_o   (rs1),
    .rs2_o   (rs2),
    .rd_o    (rd)
  );

  // Raised in the decode cycle, before the bubble reaches EX
  assign illegal_insn_o = ctrl.illegal;

  //////////////////////////////////////////////////
  // Register read and forwarding
  //////////////////////////////////////////////////
  register_file registers_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .raddr_a_i (rs1),
    .raddr_b_i (rs2),
    .rdata_a_o (rf_a),
    .rdata_b_o (rf_b),
    .alu_wr_i  (alu_wr_i),
    .wb_wr_i   (wb_wr_i)
  );

  operand_forward forward_i (
    .rs1_i    (rs1),
    .rs2_i    (rs2),
    .rf_a_i   (rf_a),
    .rf_b_i   (rf_b),
    .alu_wr_i (alu_wr_i),
    .wb_wr_i  (wb_wr_i),
    .fwd_a_o  (fwd_a),
    .fwd_b_o  (fwd_b)
  );

  //////////////////////////////////////////////////
  // Operands and ID/EX
  //////////////////////////////////////////////////
  operand_select select_i (
    .ctrl_i  (ctrl),
    .imm_i   (imm),
    .pc_i    (pc_id_i),
    .fwd_a_i (fwd_a),
    .fwd_b_i (fwd_b),
    .op_a_o  (op_a),
    .op_b_o  (op_b),
    .op_c_o  (op_c)
  );

  // Store data is the forwarded rs2
  id_ex_regs pipe_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .stall_i   (stall_ex_i),
    .ctrl_i    (ctrl),
    .op_a_i    (op_a),
    .op_b_i    (op_b),
    .op_c_i    (op_c),
    .rb_data_i (fwd_b),
    .rd_i      (rd),
    .ex_o      (ex_o)
  );

endmodule

// ==== verification/id_stage_model.svh ====
// Reference model of the decode stage, included inside the testbench module body
`ifndef ID_STAGE_MODEL_SVH
`define ID_STAGE_MODEL_SVH

  // Mirror of the architectural registers, x0 kept at zero
  logic [XLEN-1:0] mirror_regs [0:NUM_REGS-1];

  task automatic model_reset();
    for (int i = 0; i < NUM_REGS; i++)
      mirror_regs[i] = '0;
  endtask

  // WB first, then ALU on top, so the ALU port wins a collision
  task automatic model_write(input rf_write_t alu, input rf_write_t wb);
    if (wb.we && (wb.waddr != 0))
      mirror_regs[wb.waddr] = wb.wdata;
    if (alu.we && (alu.waddr != 0))
      mirror_regs[alu.waddr] = alu.wdata;
  endtask

  // Register read as seen in decode, pending writes bypassed
  function automatic logic [XLEN-1:0] model_read(input logic [4:0] addr,
                                                 input rf_write_t alu, input rf_write_t wb);
    if (addr == 0)
      return '0;
    if (alu.we && (alu.waddr == addr))
      return alu.wdata;
    if (wb.we && (wb.waddr == addr))
      return wb.wdata;
    return mirror_regs[addr];
  endfunction

  // Integer operator from funct3, alt set for SUB and SRA
  function automatic alu_op_e alu_for_funct3(input logic [2:0] f3, input logic alt);
    alu_op_e op;
    case (f3)
      3'd0: op = alt ? ALU_SUB : ALU_ADD;
      3'd1: op = ALU_SLL;
      3'd2: op = ALU_SLT;
      3'd3: op = ALU_SLTU;
      3'd4: op = ALU_XOR;
      3'd5: op = alt ? ALU_SRA : ALU_SRL;
      3'd6: op = ALU_OR;
      3'd7: op = ALU_AND;
    endcase
    return op;
  endfunction

  // Expected ID/EX bundle and illegal flag for one instruction
  task automatic model_expect(input instr_u ins, input logic [XLEN-1:0] pc,
                              input rf_write_t alu, input rf_write_t wb,
                              output id_ex_t exp, output logic illegal);
    logic [31:0] w;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] va;
    logic [31:0] vb;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    w  = ins;
    f3 = ins.r.funct3;
    f7 = ins.r.funct7;
    va = model_read(ins.r.rs1, alu, wb);
    vb = model_read(ins.r.rs2, alu, wb);
    // Immediates straight from the spec bit positions
    imm_i = {{20{w[31]}}, w[31:20]};
    imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
    imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    imm_u = {w[31:12], 12'h000};
    imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    exp           = '0;
    illegal       = 1'b0;
    exp.rb_data   = vb;
    exp.operand_a = va;
    exp.operand_b = vb;
    exp.operand_c = vb;
    exp.alu_waddr = ins.r.rd;
    exp.waddr     = ins.r.rd;
    case (ins.r.opcode)
      OPCODE_OP:
      begin
        illegal    = !((f7 == 7'h00) || ((f7 == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5))));
        exp.alu_op = alu_for_funct3(f3, f7[5]);
        exp.alu_we = 1'b1;
      end
      OPCODE_OPIMM:
      begin
        if (f3 == 3'd1)
          illegal = (f7 != 7'h00);
        if (f3 == 3'd5)
          illegal = (f7 != 7'h00) && (f7 != 7'h20);
        exp.alu_op    = alu_for_funct3(f3, (f3 == 3'd5) && f7[5]);
        exp.operand_b = imm_i;
        exp.alu_we    = 1'b1;
      end
      OPCODE_LUI, OPCODE_AUIPC:
      begin
        exp.alu_op    = ALU_ADD;
        exp.operand_a = (ins.r.opcode == OPCODE_LUI) ? 32'd0 : pc;
        exp.operand_b = imm_u;
        exp.alu_we    = 1'b1;
      end
      OPCODE_JAL, OPCODE_JALR:
      begin
        // Link is PC + 4 through the ALU
        exp.alu_op    = ALU_ADD;
        exp.operand_a = pc;
        exp.operand_b = 32'd4;
        exp.alu_we    = 1'b1;
        if (ins.r.opcode == OPCODE_JAL)
        begin
          exp.jump      = JUMP_JAL;
          exp.operand_c = pc + imm_j;
        end
        else
        begin
          illegal       = (f3 != 3'd0);
          exp.jump      = JUMP_JALR;
          exp.operand_c = va + imm_i;
        end
      end
      OPCODE_BRANCH:
      begin
        exp.jump      = JUMP_BRANCH;
        exp.operand_c = pc + imm_b;
        case (f3)
          3'd0:    exp.alu_op = ALU_EQ;
          3'd1:    exp.alu_op = ALU_NE;
          3'd4:    exp.alu_op = ALU_SLT;
          3'd5:    exp.alu_op = ALU_GE;
          3'd6:    exp.alu_op = ALU_SLTU;
          3'd7:    exp.alu_op = ALU_GEU;
          default: illegal = 1'b1;
        endcase
      end
      OPCODE_LOAD, OPCODE_STORE:
      begin
        exp.alu_op   = ALU_ADD;
        exp.data_req = 1'b1;
        if (f3[1:0] == 2'd0)
          exp.data_type = DATA_TYPE_BYTE;
        else if (f3[1:0] == 2'd1)
          exp.data_type = DATA_TYPE_HALF;
        else
          exp.data_type = DATA_TYPE_WORD;
        if (ins.r.opcode == OPCODE_LOAD)
        begin
          // LB LH LW LBU LHU only
          illegal            = (f3 == 3'd3) || (f3 > 3'd5);
          exp.operand_b      = imm_i;
          exp.we             = 1'b1;
          exp.data_sign_ext  = !f3[2];
        end
        else
        begin
          illegal       = (f3 > 3'd2);
          exp.operand_b = imm_s;
          exp.data_we   = 1'b1;
        end
      end
      default: illegal = 1'b1;
    endcase
    // Illegal words become a bubble
    if (illegal)
      exp = '0;
  endtask

`endif

// ==== verification/tb_id_stage.sv ====
// Self-checking testbench for the decode stage, random instructions against the included model
`timescale 1ns/1ps

module tb_id_stage
  import id_pkg::*;
();

  localparam int N_CYCLES   = 2000;
  localparam int RST_CYCLES = 3;
  localparam int CLK_PERIOD = 8;
  localparam int TIMEOUT_NS = (N_CYCLES + RST_CYCLES + 20) * CLK_PERIOD;

  logic        clk;
  logic        rst_n;
  logic [31:0] instr_rdata;
  logic [31:0] pc_id;
  logic        stall_ex;
  rf_write_t   alu_wr;
  rf_write_t   wb_wr;
  id_ex_t      ex;
  logic        illegal_insn;

  integer seed;
  int     error_count;
  int     check_count;
  id_ex_t exp_q;
  id_ex_t next_exp;
  id_ex_t cur_exp;
  logic   next_illegal;
  logic   cur_illegal;

  `include "id_stage_model.svh"

  id_stage uut (
    .clk            (clk),
    .rst_n          (rst_n),
    .instr_rdata_i  (instr_rdata),
    .pc_id_i        (pc_id),
    .stall_ex_i     (stall_ex),
    .alu_wr_i       (alu_wr),
    .wb_wr_i        (wb_wr),
    .ex_o           (ex),
    .illegal_insn_o (illegal_insn)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  //////////////////////////////////////////////////
  // Checking
  //////////////////////////////////////////////////
  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    if (actual !== expected)
    begin
      error_count++;
      $display("[ERROR] t=%0t %s expected %h actual %h", $time, name, expected, actual);
    end
  endtask

  // Field by field so a mismatch names the signal
  task automatic check_ex(input id_ex_t e);
    check_value("ex_o.alu_op", e.alu_op, ex.alu_op);
    check_value("ex_o.operand_a", e.operand_a, ex.operand_a);
    check_value("ex_o.operand_b", e.operand_b, ex.operand_b);
    check_value("ex_o.operand_c", e.operand_c, ex.operand_c);
    check_value("ex_o.rb_data", e.rb_data, ex.rb_data);
    check_value("ex_o.alu_waddr", e.alu_waddr, ex.alu_waddr);
    check_value("ex_o.alu_we", e.alu_we, ex.alu_we);
    check_value("ex_o.waddr", e.waddr, ex.waddr);
    check_value("ex_o.we", e.we, ex.we);
    check_value("ex_o.data_req", e.data_req, ex.data_req);
    check_value("ex_o.data_we", e.data_we, ex.data_we);
    check_value("ex_o.data_type", e.data_type, ex.data_type);
    check_value("ex_o.data_sign_ext", e.data_sign_ext, ex.data_sign_ext);
    check_value("ex_o.jump", e.jump, ex.jump);
  endtask

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////
  function automatic bit chance(input int pct);
    return ($unsigned($random(seed)) % 100) < pct;
  endfunction

  // Mostly legal words over the nine opcodes, a few raw random words
  function automatic logic [31:0] gen_instr();
    logic [31:0] r;
    logic [2:0]  f3;
    logic [6:0]  f7;
    int          kind;
    r = $random(seed);
    if (chance(5))
      return r;
    kind = $unsigned($random(seed)) % 9;
    f3   = r[14:12];
    f7   = (r[30] && ((f3 == 3'd0) || (f3 == 3'd5))) ? 7'h20 : 7'h00;
    case (kind)
      0: return {f7, r[24:15], f3, r[11:7], OPCODE_OP};
      1:
      begin
        // Shifts need a clean funct7, no SUBI
        if ((f3 == 3'd1) || (f3 == 3'd5))
          return {(f3 == 3'd5) ? f7 : 7'h00, r[24:7], OPCODE_OPIMM};
        return {r[31:7], OPCODE_OPIMM};
      end
      2: return {r[31:7], OPCODE_LUI};
      3: return {r[31:7], OPCODE_AUIPC};
      4: return {r[31:7], OPCODE_JAL};
      5: return {r[31:15], 3'd0, r[11:7], OPCODE_JALR};
      6:
      begin
        // Remap the two reserved branch codes
        if (f3 == 3'd2)
          f3 = 3'd0;
        else if (f3 == 3'd3)
          f3 = 3'd7;
        return {r[31:15], f3, r[11:7], OPCODE_BRANCH};
      end
      7:
      begin
        if (f3 == 3'd3)
          f3 = 3'd2;
        else if (f3 > 3'd5)
          f3 = f3 - 3'd2;
        return {r[31:15], f3, r[11:7], OPCODE_LOAD};
      end
      default: return {r[31:15], 3'(f3 % 3), r[11:7], OPCODE_STORE};
    endcase
  endfunction

  // Write port aimed at rs1 or rs2 half of the time
  function automatic rf_write_t gen_write(input logic [31:0] w);
    rf_write_t p;
    int        sel;
    sel     = $unsigned($random(seed)) % 4;
    p.we    = chance(50);
    p.wdata = $random(seed);
    case (sel)
      0:       p.waddr = w[19:15];
      1:       p.waddr = w[24:20];
      default: p.waddr = $random(seed);
    endcase
    return p;
  endfunction

  task automatic drive_inputs();
    logic [31:0] w;
    w = gen_instr();
    instr_rdata <= w;
    pc_id       <= $random(seed) & 32'hffff_fffc;
    stall_ex    <= chance(15);
    alu_wr      <= gen_write(w);
    wb_wr       <= gen_write(w);
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////
  initial
  begin
    seed        = 32'h3374;
    error_count = 0;
    check_count = 0;
    clk         = 1'b0;
    rst_n       <= 1'b0;
    instr_rdata <= '0;
    pc_id       <= '0;
    stall_ex    <= 1'b0;
    alu_wr      <= '0;
    wb_wr       <= '0;
    exp_q       = '0;
    model_reset();
    repeat (RST_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    drive_inputs();
    // Bubble before the first enabled edge
    @(negedge clk);
    check_ex('0);
    for (int i = 0; i < N_CYCLES; i++)
    begin
      @(posedge clk);
      // Inputs read here are the ones the DUT samples at this edge
      if (!stall_ex)
      begin
        model_expect(instr_rdata, pc_id, alu_wr, wb_wr, next_exp, next_illegal);
        exp_q = next_exp;
      end
      model_write(alu_wr, wb_wr);
      drive_inputs();
      @(negedge clk);
      check_ex(exp_q);
      // Flag belongs to the word now in decode
      model_expect(instr_rdata, pc_id, alu_wr, wb_wr, cur_exp, cur_illegal);
      check_value("illegal_insn_o", cur_illegal, illegal_insn);
    end
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

  // Watchdog
  initial
  begin
    #(TIMEOUT_NS);
    $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

// ==== id_stage.f ====
verilog/id_pkg.sv
verilog/instr_decoder.sv
verilog/register_file.sv
verilog/operand_forward.sv
verilog/operand_select.sv
verilog/id_ex_regs.sv
verilog/id_stage.sv
+incdir+verification
verification/tb_id_stage.sv
